// File: fe_pkg.sv
`default_nettype none

package fe_pkg;

    // Instruction word width
    localparam int XLEN = 32;

    // Width of the program counter and of fetch addresses
    localparam int PADDR_W = 32;

    // Instruction memory size in words
    localparam int IMEM_WORDS = 256;

    // Word index width into the instruction memory
    localparam int IMEM_AW = 8;

    // MISC-MEM opcode (fence), used here to mark the end of a program
    localparam logic [6:0] OPCODE_MISC = 7'b0001111;

    // Byte step between consecutive instructions
    localparam logic [PADDR_W-1:0] PC_STEP = 4;

    // Fetch control states
    // FE_IDLE   after reset, one cycle before the first request
    // FE_REQ    first request goes out
    // FE_PEND   waiting on the fetch buffer, or passing a live response on
    // FE_HOLD   response captured while decode stalls
    // FE_HALT   halt instruction consumed, parked until reset
    typedef enum logic [2:0] {
        FE_IDLE = 3'd0,
        FE_REQ  = 3'd1,
        FE_PEND = 3'd2,
        FE_HOLD = 3'd3,
        FE_HALT = 3'd4
    } t_fe_state;

endpackage

`default_nettype wire

// File: fe_imem.sv
`timescale 1ns/100ps
`default_nettype none

// Word-addressed instruction memory
// One synchronous read port and one synchronous write port for loading
module fe_imem (
    input  logic                       clk,

    // Read port, data appears the cycle after rd_en
    input  logic                       rd_en,
    input  logic [fe_pkg::IMEM_AW-1:0] rd_idx,
    output logic [fe_pkg::XLEN-1:0]    rd_data,

    // Program load port
    input  logic                       wr,
    input  logic [fe_pkg::IMEM_AW-1:0] wr_idx,
    input  logic [fe_pkg::XLEN-1:0]    wr_data
);

    // Storage array
    logic [fe_pkg::XLEN-1:0] mem [fe_pkg::IMEM_WORDS];

    // Write port
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // Registered read, output holds its value between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: fe_fb.sv
`timescale 1ns/100ps
`default_nettype none

// Fetch buffer
// A request sampled at one edge comes back as a one-cycle response
// two edges later. The request stage drives the memory read, the read
// stage keeps the PC lined up with the memory output register, and the
// response register takes the word so control never sees a raw RAM path.
module fe_fb (
    input  logic                       clk,
    input  logic                       reset,

    // Request from fetch control
    input  logic                       req,
    input  logic [fe_pkg::PADDR_W-1:0] req_addr,

    // Response to fetch control
    output logic                       rsp_valid,
    output logic [fe_pkg::XLEN-1:0]    rsp_instr,
    output logic [fe_pkg::PADDR_W-1:0] rsp_pc,

    // Instruction memory read port
    output logic                       rd_en,
    output logic [fe_pkg::IMEM_AW-1:0] rd_idx,
    input  logic [fe_pkg::XLEN-1:0]    rd_data
);

    // Request stage
    logic                       s1_valid;
    logic [fe_pkg::PADDR_W-1:0] s1_pc;

    // Read stage, in step with the memory output register
    logic                       s2_valid;
    logic [fe_pkg::PADDR_W-1:0] s2_pc;

    // Valid pipe
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            s1_valid  <= req;
            s2_valid  <= s1_valid;
            rsp_valid <= s2_valid;
        end
    end

    // PC pipe, loaded only when its stage carries a request
    always_ff @(posedge clk) begin
        if (req) begin
            s1_pc <= req_addr;
        end
        if (s1_valid) begin
            s2_pc <= s1_pc;
        end
    end

    // Response register
    always_ff @(posedge clk) begin
        if (s2_valid) begin
            rsp_instr <= rd_data;
            rsp_pc    <= s2_pc;
        end
    end

    // Memory read, word index from address bits above the byte offset
    // so the space wraps every IMEM_WORDS words
    assign rd_en  = s1_valid;
    assign rd_idx = s1_pc[fe_pkg::IMEM_AW+1:2];

endmodule

`default_nettype wire

// File: fe_ctl.sv
`timescale 1ns/100ps
`default_nettype none

// Fetch control
// Keeps the PC, issues one fetch at a time and hands instructions to
// decode. A response that meets a stall is parked in a capture register
// until decode takes it. A fence opcode ends the program.
module fe_ctl (
    input  logic                       clk,
    input  logic                       reset,

    // Request to the fetch buffer
    output logic                       fb_req,
    output logic [fe_pkg::PADDR_W-1:0] fb_req_addr,

    // Response from the fetch buffer
    input  logic                       rsp_valid,
    input  logic [fe_pkg::XLEN-1:0]    rsp_instr,
    input  logic [fe_pkg::PADDR_W-1:0] rsp_pc,

    // Decode interface
    output logic                       valid_fe1,
    output logic [fe_pkg::XLEN-1:0]    instr_fe1,
    output logic [fe_pkg::PADDR_W-1:0] pc_fe1,
    input  logic                       stall
);

    fe_pkg::t_fe_state state;
    fe_pkg::t_fe_state state_nxt;

    logic [fe_pkg::PADDR_W-1:0] pc;

    // Captured response
    logic [fe_pkg::XLEN-1:0]    cap_instr;
    logic [fe_pkg::PADDR_W-1:0] cap_pc;

    // Halt decode on the live and the captured word
    logic rsp_halt;
    logic cap_halt;

    assign rsp_halt = rsp_instr[6:0] == fe_pkg::OPCODE_MISC;
    assign cap_halt = cap_instr[6:0] == fe_pkg::OPCODE_MISC;

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            fe_pkg::FE_IDLE: begin
                state_nxt = fe_pkg::FE_REQ;
            end
            fe_pkg::FE_REQ: begin
                state_nxt = fe_pkg::FE_PEND;
            end
            fe_pkg::FE_PEND: begin
                if (rsp_valid) begin
                    if (stall) begin
                        state_nxt = fe_pkg::FE_HOLD;
                    end else if (rsp_halt) begin
                        state_nxt = fe_pkg::FE_HALT;
                    end
                end
            end
            fe_pkg::FE_HOLD: begin
                if (!stall) begin
                    state_nxt = cap_halt ? fe_pkg::FE_HALT : fe_pkg::FE_PEND;
                end
            end
            default: begin
                state_nxt = state;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fe_pkg::FE_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Request goes out at start, or when the current item is consumed
    // and it is not the halt
    assign fb_req = (state == fe_pkg::FE_REQ)
                  | (state == fe_pkg::FE_PEND & rsp_valid & !stall & !rsp_halt)
                  | (state == fe_pkg::FE_HOLD & !stall & !cap_halt);

    assign fb_req_addr = pc;

    // PC moves on with every request
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (fb_req) begin
            pc <= pc + fe_pkg::PC_STEP;
        end
    end

    // Capture each response for FE_HOLD
    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            cap_instr <= rsp_instr;
            cap_pc    <= rsp_pc;
        end
    end

    // Decode outputs, live response in FE_PEND, captured one in FE_HOLD
    assign valid_fe1 = (state == fe_pkg::FE_PEND & rsp_valid)
                     | (state == fe_pkg::FE_HOLD);

    assign instr_fe1 = (state == fe_pkg::FE_HOLD) ? cap_instr : rsp_instr;
    assign pc_fe1    = (state == fe_pkg::FE_HOLD) ? cap_pc    : rsp_pc;

endmodule

`default_nettype wire

// File: fe_top.sv
`timescale 1ns/100ps
`default_nettype none

// Instruction front end
// Fetch control, fetch buffer and instruction memory
module fe_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,

    // Program load
    input  logic                       imem_wr,
    input  logic [fe_pkg::IMEM_AW-1:0] imem_wr_idx,
    input  logic [fe_pkg::XLEN-1:0]    imem_wr_data,

    // To decode
    output logic                       valid_fe1,
    output logic [fe_pkg::XLEN-1:0]    instr_fe1,
    output logic [fe_pkg::PADDR_W-1:0] pc_fe1
);

    // Control to fetch buffer
    logic                       fb_req;
    logic [fe_pkg::PADDR_W-1:0] fb_req_addr;
    logic                       rsp_valid;
    logic [fe_pkg::XLEN-1:0]    rsp_instr;
    logic [fe_pkg::PADDR_W-1:0] rsp_pc;

    // Fetch buffer to memory
    logic                       rd_en;
    logic [fe_pkg::IMEM_AW-1:0] rd_idx;
    logic [fe_pkg::XLEN-1:0]    rd_data;

    fe_ctl u_ctl (
        .clk         (clk),
        .reset       (reset),
        .fb_req      (fb_req),
        .fb_req_addr (fb_req_addr),
        .rsp_valid   (rsp_valid),
        .rsp_instr   (rsp_instr),
        .rsp_pc      (rsp_pc),
        .valid_fe1   (valid_fe1),
        .instr_fe1   (instr_fe1),
        .pc_fe1      (pc_fe1),
        .stall       (stall)
    );

    fe_fb u_fb (
        .clk       (clk),
        .reset     (reset),
        .req       (fb_req),
        .req_addr  (fb_req_addr),
        .rsp_valid (rsp_valid),
        .rsp_instr (rsp_instr),
        .rsp_pc    (rsp_pc),
        .rd_en     (rd_en),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data)
    );

    fe_imem u_imem (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .wr      (imem_wr),
        .wr_idx  (imem_wr_idx),
        .wr_data (imem_wr_data)
    );

endmodule

`default_nettype wire

// File: tb_fe_checks.svh
`ifndef TB_FE_CHECKS_SVH
`define TB_FE_CHECKS_SVH

// Compare tasks for the decode outputs
// Each one stops the run on its first mismatch

// Instruction word
task automatic check_instr(
    input string                   name,
    input logic [fe_pkg::XLEN-1:0] expected,
    input logic [fe_pkg::XLEN-1:0] actual
);
    if (actual !== expected) begin
        $display("mismatch %s expected 0x%h actual 0x%h", name, expected, actual);
        abort_run();
    end
endtask

// Program counter
task automatic check_pc(
    input string                      name,
    input logic [fe_pkg::PADDR_W-1:0] expected,
    input logic [fe_pkg::PADDR_W-1:0] actual
);
    if (actual !== expected) begin
        $display("mismatch %s expected 0x%h actual 0x%h", name, expected, actual);
        abort_run();
    end
endtask

// Single-bit levels
task automatic check_valid(
    input string name,
    input logic  expected,
    input logic  actual
);
    if (actual !== expected) begin
        $display("mismatch %s expected 0x%h actual 0x%h", name, expected, actual);
        abort_run();
    end
endtask

`endif

// File: tb_fe.sv
`timescale 1ns/100ps
`default_nettype none

// Testbench for the instruction front end
module tb_fe;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int POST_HALT     = 30;
    localparam int STALL_PCT     = 40;
    localparam int INSTR_BYTES   = 4;
    // Edges from the first edge that samples reset low to the first item
    localparam int START_LATENCY = 3;
    localparam int MAX_CYCLES    = 20 * fe_pkg::IMEM_WORDS * 2;

    logic                       clk;
    logic                       reset;
    logic                       stall;
    logic                       imem_wr;
    logic [fe_pkg::IMEM_AW-1:0] imem_wr_idx;
    logic [fe_pkg::XLEN-1:0]    imem_wr_data;
    logic                       valid_fe1;
    logic [fe_pkg::XLEN-1:0]    instr_fe1;
    logic [fe_pkg::PADDR_W-1:0] pc_fe1;

    integer seed;

    // Model copy of the loaded program
    logic [fe_pkg::XLEN-1:0] prog [fe_pkg::IMEM_WORDS];

    // Run progress that the watchdog reads
    bit run_active;
    bit run_halted;
    int run_cycles;
    int run_stalls;
    int run_h;

    fe_top dut (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .imem_wr      (imem_wr),
        .imem_wr_idx  (imem_wr_idx),
        .imem_wr_data (imem_wr_data),
        .valid_fe1    (valid_fe1),
        .instr_fe1    (instr_fe1),
        .pc_fe1       (pc_fe1)
    );

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_fe_checks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Random words with the halt opcode only at index h
    task automatic build_program(input int h);
        logic [fe_pkg::XLEN-1:0] w;
        for (int i = 0; i <= h; i++) begin
            w = $random(seed);
            if (i == h) begin
                w[6:0] = fe_pkg::OPCODE_MISC;
            end else if (w[6:0] == fe_pkg::OPCODE_MISC) begin
                w[6] = ~w[6];
            end
            prog[i] = w;
        end
    endtask

    // Reset for 16 cycles and write the program meanwhile
    task automatic load_program(input int h);
        build_program(h);
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            reset <= 1'b1;
            stall <= 1'b0;
            if (i <= h) begin
                imem_wr      <= 1'b1;
                imem_wr_idx  <= i[fe_pkg::IMEM_AW-1:0];
                imem_wr_data <= prog[i];
            end else begin
                imem_wr <= 1'b0;
            end
            @(negedge clk);
            check_valid("valid_fe1", 1'b0, valid_fe1);
        end
    endtask

    task automatic drive_stall(input bit hold_low);
        logic [31:0] r;
        r = $random(seed);
        if (hold_low) begin
            stall <= 1'b0;
        end else begin
            stall <= (r % 100) < STALL_PCT;
        end
    endtask

    // Release reset and follow the stream to halt and beyond
    task automatic run_to_halt(input int h, input bit check_start);
        int                         c;
        int                         k;
        int                         post;
        bit                         seen_first;
        bit                         held;
        logic [fe_pkg::PADDR_W-1:0] exp_pc;
        c          = 0;
        k          = 0;
        post       = 0;
        seen_first = 1'b0;
        held       = 1'b0;
        run_h      = h;
        run_cycles = 0;
        run_stalls = 0;
        run_halted = 1'b0;
        run_active = 1'b1;
        while (post < POST_HALT) begin
            @(posedge clk);
            if (c == 0) begin
                reset   <= 1'b0;
                imem_wr <= 1'b0;
                stall   <= 1'b0;
            end else begin
                drive_stall(check_start && k == 0);
            end
            @(negedge clk);
            run_cycles = c + 1;
            if (stall && !run_halted) begin
                run_stalls++;
            end
            if (c == 0) begin
                check_valid("valid_fe1", 1'b0, valid_fe1);
            end
            if (check_start && !seen_first) begin
                check_valid("valid_fe1", c == 1 + START_LATENCY, valid_fe1);
            end
            // Item shown under stall must stay put
            if (held) begin
                exp_pc = k * INSTR_BYTES;
                check_valid("valid_fe1", 1'b1, valid_fe1);
                check_instr("instr_fe1", prog[k], instr_fe1);
                check_pc("pc_fe1", exp_pc, pc_fe1);
            end
            if (run_halted) begin
                check_valid("valid_fe1", 1'b0, valid_fe1);
                post++;
            end else if (valid_fe1 && !stall) begin
                exp_pc = k * INSTR_BYTES;
                check_pc("pc_fe1", exp_pc, pc_fe1);
                check_instr("instr_fe1", prog[k], instr_fe1);
                if (k == h) begin
                    run_halted = 1'b1;
                end
                k++;
            end
            if (valid_fe1) begin
                seen_first = 1'b1;
            end
            held = valid_fe1 && stall;
            c++;
        end
        run_active = 1'b0;
    endtask

    // Watchdog budget grows with program length and stalls
    initial begin : watchdog
        int total;
        total = 0;
        forever begin
            @(posedge clk);
            total++;
            if (total > MAX_CYCLES ||
                (run_active && !run_halted &&
                 run_cycles > 2 * (run_h + 1) * 3 + run_stalls)) begin
                $display("timeout: front end did not reach halt");
                abort_run();
            end
        end
    end

    initial begin : main
        int          h1;
        int          h2;
        logic [31:0] r;
        seed         = 32'h5861e752;
        reset        = 1'b1;
        stall        = 1'b0;
        imem_wr      = 1'b0;
        imem_wr_idx  = '0;
        imem_wr_data = '0;
        run_active   = 1'b0;
        run_halted   = 1'b0;
        run_cycles   = 0;
        run_stalls   = 0;
        run_h        = 0;

        // Halt index small enough to load within the reset window
        r  = $random(seed);
        h1 = 4 + int'(r % 12);
        h2 = h1;
        while (h2 == h1) begin
            r  = $random(seed);
            h2 = 4 + int'(r % 12);
        end

        load_program(h1);
        run_to_halt(h1, 1'b1);
        load_program(h2);
        run_to_halt(h2, 1'b0);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
fe_pkg.sv
fe_imem.sv
fe_fb.sv
fe_ctl.sv
fe_top.sv
tb_fe.sv
